// File: all.f
common/soc_pkg.sv
design/bus_arbiter.sv
design/address_decoder.sv
bram/bram.sv
clint/clint.sv
design/soc.sv
sim/soc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= soc_tb
LOG ?= sim.log
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/soc_tb.sv
`timescale 1ns/1ps

module soc_tb;

  logic clock;
  logic reset;
  logic fetch_valid;
  soc_pkg::addr_t fetch_addr;
  soc_pkg::word_t fetch_rdata;
  logic fetch_error;
  logic fetch_ready;
  logic data_valid;
  soc_pkg::addr_t data_addr;
  soc_pkg::word_t data_wdata;
  soc_pkg::strb_t data_wstrb;
  soc_pkg::word_t data_rdata;
  logic data_error;
  logic data_ready;
  logic msip;
  logic mtip;
  soc_pkg::time_t mtime;

  // Reference models, and the expected response of the request in flight on each port
  soc_pkg::word_t ram_model [soc_pkg::bram_words];
  logic ram_known [soc_pkg::bram_words];
  soc_pkg::addr_t ram_words [$];
  soc_pkg::time_t mtimecmp_shadow = '1;
  soc_pkg::time_t mtime_prev;
  logic msip_shadow = 1'b0;
  logic mtip_expect;
  logic last_was_data;
  soc_pkg::word_t exp_fetch_rdata = '0;
  soc_pkg::word_t exp_data_rdata = '0;
  logic exp_fetch_error = 1'b0;
  logic exp_data_error = 1'b0;
  logic check_fetch_rdata = 1'b0;
  logic check_data_rdata = 1'b0;
  logic check_mtime = 1'b0;
  logic check_mtip = 1'b0;
  logic [31:0] lfsr = 32'h118739f1;
  int errors = 0;
  int transfers = 0;
  int cycles = 0;

  soc dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // A timer comparison only shows on mtip one cycle later
  always @(posedge clock) begin
    mtime_prev <= mtime;
    mtip_expect <= (mtime >= mtimecmp_shadow);
    if (reset) begin
      last_was_data <= 1'b1;
    end else if (fetch_ready) begin
      last_was_data <= 1'b0;
    end else if (data_ready) begin
      last_was_data <= 1'b1;
    end
  end

  task automatic show_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
    errors++;
    $display("MISMATCH %s got %h expected %h", name, got, expected);
  endtask

  task automatic fail_check(input string what);
    errors++;
    $display("soc_tb: %s", what);
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit
  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    logic feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], feedback};
      value = {value[30:0], feedback};
    end
    return value;
  endfunction

  function automatic soc_pkg::word_t merge_bytes(soc_pkg::word_t old, soc_pkg::word_t data,
                                                 soc_pkg::strb_t strb);
    soc_pkg::word_t result;
    result = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) result[8*i +: 8] = data[8*i +: 8];
    end
    return result;
  endfunction

  task automatic fetch_access(input soc_pkg::addr_t addr);
    exp_fetch_error = !(addr < soc_pkg::bram_top);
    exp_fetch_rdata = exp_fetch_error ? '0 : ram_model[addr[11:2]];
    check_fetch_rdata = exp_fetch_error || ram_known[addr[11:2]];
    fetch_addr = addr;
    fetch_valid = 1'b1;
    do @(negedge clock); while (!fetch_ready);
    @(posedge clock);
    #1;
    fetch_valid = 1'b0;
    transfers++;
    @(posedge clock);
    #1;
  endtask

  task automatic data_access(input soc_pkg::addr_t addr, input soc_pkg::word_t wdata,
                             input soc_pkg::strb_t wstrb);
    soc_pkg::bram_index_t idx;
    soc_pkg::addr_t off;
    idx = addr[11:2];
    off = addr - soc_pkg::clint_base;
    exp_data_error = 1'b0;
    exp_data_rdata = '0;
    check_data_rdata = 1'b1;
    check_mtime = 1'b0;
    if (addr < soc_pkg::bram_top) begin
      exp_data_rdata = ram_model[idx];
      check_data_rdata = ram_known[idx];
    end else if (addr >= soc_pkg::clint_base && addr < soc_pkg::clint_top) begin
      check_data_rdata = (wstrb == '0);
      case (off)
        soc_pkg::clint_msip_off: exp_data_rdata = {31'b0, msip_shadow};
        soc_pkg::clint_mtimecmp_lo_off: exp_data_rdata = mtimecmp_shadow[31:0];
        soc_pkg::clint_mtimecmp_hi_off: exp_data_rdata = mtimecmp_shadow[63:32];
        soc_pkg::clint_mtime_lo_off: begin
          check_mtime = check_data_rdata;
          check_data_rdata = 1'b0;
        end
        soc_pkg::clint_mtime_hi_off: check_data_rdata = 1'b0;
        default: exp_data_rdata = '0;
      endcase
      if (off == soc_pkg::clint_msip_off && wstrb[0]) msip_shadow = wdata[0];
      if (off == soc_pkg::clint_mtimecmp_lo_off) begin
        mtimecmp_shadow[31:0] = merge_bytes(mtimecmp_shadow[31:0], wdata, wstrb);
      end
      if (off == soc_pkg::clint_mtimecmp_hi_off) begin
        mtimecmp_shadow[63:32] = merge_bytes(mtimecmp_shadow[63:32], wdata, wstrb);
      end
    end else begin
      exp_data_error = 1'b1;
    end
    data_addr = addr;
    data_wdata = wdata;
    data_wstrb = wstrb;
    data_valid = 1'b1;
    do @(negedge clock); while (!data_ready);
    @(posedge clock);
    #1;
    data_valid = 1'b0;
    transfers++;
    if (addr < soc_pkg::bram_top && wstrb != '0) begin
      ram_model[idx] = merge_bytes(ram_model[idx], wdata, wstrb);
      ram_known[idx] = ram_known[idx] || (wstrb == 4'hf);
    end
    @(posedge clock);
    #1;
  endtask

  assert property (@(posedge clock) $fell(reset) |->
    !fetch_ready && !data_ready && !msip && !mtip && mtime == '0)
    else fail_check("outputs were not at their reset values after reset");
  assert property (@(posedge clock) disable iff (reset)
    data_ready |-> data_error == exp_data_error)
    else show_mismatch("data_error", 64'($sampled(data_error)), 64'(exp_data_error));
  assert property (@(posedge clock) disable iff (reset)
    data_ready && check_data_rdata |-> data_rdata == exp_data_rdata)
    else show_mismatch("data_rdata", 64'($sampled(data_rdata)), 64'(exp_data_rdata));
  assert property (@(posedge clock) disable iff (reset)
    data_ready && check_mtime |-> data_rdata == mtime_prev[31:0])
    else show_mismatch("data_rdata", 64'($sampled(data_rdata)),
                       64'($sampled(mtime_prev[31:0])));
  assert property (@(posedge clock) disable iff (reset)
    fetch_ready |-> fetch_error == exp_fetch_error)
    else show_mismatch("fetch_error", 64'($sampled(fetch_error)), 64'(exp_fetch_error));
  assert property (@(posedge clock) disable iff (reset)
    fetch_ready && check_fetch_rdata |-> fetch_rdata == exp_fetch_rdata)
    else show_mismatch("fetch_rdata", 64'($sampled(fetch_rdata)), 64'(exp_fetch_rdata));
  assert property (@(posedge clock) disable iff (reset)
    $rose(data_valid) && !fetch_valid |=> data_ready)
    else fail_check("data_ready did not follow one cycle after data_valid");
  assert property (@(posedge clock) disable iff (reset)
    $rose(fetch_valid) && !data_valid |=> fetch_ready)
    else fail_check("fetch_ready did not follow one cycle after fetch_valid");
  assert property (@(posedge clock) disable iff (reset)
    $rose(fetch_valid) && $rose(data_valid) && last_was_data |=>
    (fetch_ready && !data_ready) ##1 !data_ready ##1 (data_ready && !fetch_ready))
    else fail_check("contested request did not serve the fetch port and then the data port");
  assert property (@(posedge clock) disable iff (reset)
    $rose(fetch_valid) && $rose(data_valid) && !last_was_data |=>
    (data_ready && !fetch_ready) ##1 !fetch_ready ##1 (fetch_ready && !data_ready))
    else fail_check("contested request did not serve the data port and then the fetch port");
  assert property (@(posedge clock) disable iff (reset) !data_valid |-> msip == msip_shadow)
    else show_mismatch("msip", 64'($sampled(msip)), 64'(msip_shadow));
  assert property (@(posedge clock) disable iff (reset) check_mtip |-> mtip == mtip_expect)
    else show_mismatch("mtip", 64'($sampled(mtip)), 64'($sampled(mtip_expect)));

  // About 200 transfers of a few cycles each, with a wide margin
  initial begin
    while (cycles < 4000) begin
      @(posedge clock);
      cycles++;
    end
    $display("soc_tb: timeout, the tests did not finish within %0d cycles", cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    soc_pkg::addr_t addr;
    soc_pkg::addr_t other;
    soc_pkg::time_t target;
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    data_valid = 1'b0;
    data_addr = '0;
    data_wdata = '0;
    data_wstrb = '0;
    for (int i = 0; i < soc_pkg::bram_words; i++) ram_known[i] = 1'b0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    @(posedge clock);
    #1;

    // RAM writes, partial writes, then reads back
    for (int i = 0; i < 32; i++) begin
      addr = rand_bits(10) << 2;
      ram_words.push_back(addr);
      data_access(addr, rand_bits(32), 4'hf);
    end
    for (int i = 0; i < 32; i++) begin
      addr = ram_words[rand_bits(5)];
      data_access(addr, rand_bits(32), 4'(rand_bits(4)));
    end
    foreach (ram_words[i]) data_access(ram_words[i], '0, '0);

    // Contested requests where a lone fetch before odd pairs lets the data port win
    for (int i = 0; i < 20; i++) begin
      addr = ram_words[rand_bits(5)];
      other = ram_words[rand_bits(5)];
      if (i % 2 == 1) begin
        fetch_access(ram_words[rand_bits(5)]);
      end
      fork
        fetch_access(addr);
        data_access(other, '0, '0);
      join
    end
    for (int i = 0; i < 8; i++) fetch_access(ram_words[rand_bits(5)]);

    // Error responses followed by a read back of the untouched RAM
    data_access(32'h1000_0000, '0, '0);
    data_access(32'h1000_0000, rand_bits(32), 4'hf);
    data_access(soc_pkg::bram_top, rand_bits(32), 4'hf);
    data_access(soc_pkg::clint_top, '0, '0);
    for (int i = 0; i < 4; i++) data_access(32'h4000_0000 | rand_bits(28), rand_bits(32), 4'hf);
    fetch_access(soc_pkg::clint_base);
    fetch_access(soc_pkg::clint_base + soc_pkg::clint_mtime_lo_off);
    fetch_access(32'h1000_0000);
    foreach (ram_words[i]) data_access(ram_words[i], '0, '0);

    // Software interrupt bit, and an offset that decodes to nothing
    data_access(soc_pkg::clint_base + soc_pkg::clint_msip_off, 32'h1, 4'h1);
    data_access(soc_pkg::clint_base + soc_pkg::clint_msip_off, '0, '0);
    data_access(soc_pkg::clint_base + soc_pkg::clint_msip_off, 32'h0, 4'h1);
    data_access(soc_pkg::clint_base + soc_pkg::clint_msip_off, '0, '0);
    data_access(soc_pkg::clint_base + 32'h8, '0, '0);

    // Timer compare a little ahead of the count
    target = mtime + 64'(rand_bits(6));
    data_access(soc_pkg::clint_base + soc_pkg::clint_mtimecmp_hi_off, target[63:32], 4'hf);
    data_access(soc_pkg::clint_base + soc_pkg::clint_mtimecmp_lo_off, target[31:0], 4'hf);
    check_mtip = 1'b1;
    while (!mtip) @(negedge clock);
    repeat (4) @(posedge clock);
    #1;
    check_mtip = 1'b0;
    data_access(soc_pkg::clint_base + soc_pkg::clint_mtimecmp_hi_off, '1, 4'hf);
    data_access(soc_pkg::clint_base + soc_pkg::clint_mtimecmp_lo_off, '1, 4'hf);
    check_mtip = 1'b1;
    data_access(soc_pkg::clint_base + soc_pkg::clint_mtimecmp_lo_off, '0, '0);

    for (int i = 0; i < 4; i++) begin
      data_access(soc_pkg::clint_base + soc_pkg::clint_mtime_lo_off, '0, '0);
    end
    repeat (4) @(posedge clock);

    $display("soc_tb: %0d transfers, %0d errors", transfers, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: design/soc.sv
`timescale 1ns/1ps

module soc (
  input  logic clock,
  input  logic reset,
  input  logic fetch_valid,
  input  soc_pkg::addr_t fetch_addr,
  output soc_pkg::word_t fetch_rdata,
  output logic fetch_error,
  output logic fetch_ready,
  input  logic data_valid,
  input  soc_pkg::addr_t data_addr,
  input  soc_pkg::word_t data_wdata,
  input  soc_pkg::strb_t data_wstrb,
  output soc_pkg::word_t data_rdata,
  output logic data_error,
  output logic data_ready,
  output logic msip,
  output logic mtip,
  output soc_pkg::time_t mtime
);

  // Shared bus between the arbiter and the decoder
  logic bus_valid;
  logic bus_instr;
  soc_pkg::addr_t bus_addr;
  soc_pkg::word_t bus_wdata;
  soc_pkg::strb_t bus_wstrb;
  soc_pkg::word_t bus_rdata;
  logic bus_error;
  logic bus_ready;

  logic bram_valid;
  soc_pkg::addr_t bram_addr;
  soc_pkg::word_t bram_wdata;
  soc_pkg::strb_t bram_wstrb;
  soc_pkg::word_t bram_rdata;
  logic bram_ready;

  logic clint_valid;
  soc_pkg::addr_t clint_addr;
  soc_pkg::word_t clint_wdata;
  soc_pkg::strb_t clint_wstrb;
  soc_pkg::word_t clint_rdata;
  logic clint_ready;

  // Port and wire names match the submodules one to one
  bus_arbiter arbiter0 (.*);

  address_decoder decoder0 (.*);

  bram bram0 (.*);

  clint clint0 (.*);

endmodule

// File: clint/clint.sv
`timescale 1ns/1ps

module clint (
  input  logic clock,
  input  logic reset,
  input  logic clint_valid,
  input  soc_pkg::addr_t clint_addr,
  input  soc_pkg::word_t clint_wdata,
  input  soc_pkg::strb_t clint_wstrb,
  output soc_pkg::word_t clint_rdata,
  output logic clint_ready,
  output logic msip,
  output logic mtip,
  output soc_pkg::time_t mtime
);

  soc_pkg::time_t mtimecmp;
  soc_pkg::word_t read_value;
  logic accept;
  logic write;

  function automatic soc_pkg::word_t merge(soc_pkg::word_t old, soc_pkg::word_t data,
                                           soc_pkg::strb_t strb);
    soc_pkg::word_t result;
    result = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = data[8*i +: 8];
      end
    end
    return result;
  endfunction

  assign accept = clint_valid && !clint_ready;
  assign write = accept && (clint_wstrb != '0);

  always_comb begin
    case (clint_addr)
      soc_pkg::clint_msip_off: read_value = {31'b0, msip};
      soc_pkg::clint_mtimecmp_lo_off: read_value = mtimecmp[31:0];
      soc_pkg::clint_mtimecmp_hi_off: read_value = mtimecmp[63:32];
      soc_pkg::clint_mtime_lo_off: read_value = mtime[31:0];
      soc_pkg::clint_mtime_hi_off: read_value = mtime[63:32];
      default: read_value = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      clint_rdata <= read_value;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
      mtimecmp <= '1;
      msip <= 1'b0;
      mtip <= 1'b0;
      clint_ready <= 1'b0;
    end else begin
      clint_ready <= accept;
      mtip <= (mtime >= mtimecmp);
      // A written half replaces the count, the other half keeps running
      mtime <= mtime + 64'd1;
      if (write) begin
        case (clint_addr)
          soc_pkg::clint_msip_off: begin
            if (clint_wstrb[0]) begin
              msip <= clint_wdata[0];
            end
          end
          soc_pkg::clint_mtimecmp_lo_off:
            mtimecmp[31:0] <= merge(mtimecmp[31:0], clint_wdata, clint_wstrb);
          soc_pkg::clint_mtimecmp_hi_off:
            mtimecmp[63:32] <= merge(mtimecmp[63:32], clint_wdata, clint_wstrb);
          soc_pkg::clint_mtime_lo_off:
            mtime[31:0] <= merge(mtime[31:0], clint_wdata, clint_wstrb);
          soc_pkg::clint_mtime_hi_off:
            mtime[63:32] <= merge(mtime[63:32], clint_wdata, clint_wstrb);
          default: begin
          end
        endcase
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) clint_ready |=> !clint_ready)
    else $error("clint: ready high in two consecutive cycles");

endmodule

// File: bram/bram.sv
`timescale 1ns/1ps

module bram (
  input  logic clock,
  input  logic reset,
  input  logic bram_valid,
  input  soc_pkg::addr_t bram_addr,
  input  soc_pkg::word_t bram_wdata,
  input  soc_pkg::strb_t bram_wstrb,
  output soc_pkg::word_t bram_rdata,
  output logic bram_ready
);

  soc_pkg::word_t mem [soc_pkg::bram_words];
  soc_pkg::bram_index_t index;
  logic accept;

  assign index = bram_addr[11:2];

  // The ready cycle still carries valid, so only the first cycle is a new access
  assign accept = bram_valid && !bram_ready;

  always_ff @(posedge clock) begin
    if (accept) begin
      for (int i = 0; i < 4; i++) begin
        if (bram_wstrb[i]) begin
          mem[index][8*i +: 8] <= bram_wdata[8*i +: 8];
        end
      end
      bram_rdata <= mem[index];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      bram_ready <= 1'b0;
    end else begin
      bram_ready <= accept;
    end
  end

  // The decoder has already stripped the region base
  assert property (@(posedge clock) disable iff (reset)
    bram_valid |-> bram_addr < soc_pkg::bram_top)
    else $error("bram: offset %h outside the RAM", bram_addr);

endmodule

// File: design/address_decoder.sv
`timescale 1ns/1ps

module address_decoder (
  input  logic clock,
  input  logic reset,
  input  logic bus_valid,
  input  logic bus_instr,
  input  soc_pkg::addr_t bus_addr,
  input  soc_pkg::word_t bus_wdata,
  input  soc_pkg::strb_t bus_wstrb,
  output soc_pkg::word_t bus_rdata,
  output logic bus_error,
  output logic bus_ready,
  output logic bram_valid,
  output soc_pkg::addr_t bram_addr,
  output soc_pkg::word_t bram_wdata,
  output soc_pkg::strb_t bram_wstrb,
  input  soc_pkg::word_t bram_rdata,
  input  logic bram_ready,
  output logic clint_valid,
  output soc_pkg::addr_t clint_addr,
  output soc_pkg::word_t clint_wdata,
  output soc_pkg::strb_t clint_wstrb,
  input  soc_pkg::word_t clint_rdata,
  input  logic clint_ready
);

  logic err_req;
  logic err_ready;
  soc_pkg::addr_t base;

  always_comb begin
    bram_valid = 1'b0;
    clint_valid = 1'b0;
    err_req = 1'b0;
    base = '0;
    if (bus_valid) begin
      if (bus_addr >= soc_pkg::bram_base && bus_addr < soc_pkg::bram_top) begin
        bram_valid = 1'b1;
        base = soc_pkg::bram_base;
      end else if (!bus_instr && bus_addr >= soc_pkg::clint_base &&
                   bus_addr < soc_pkg::clint_top) begin
        clint_valid = 1'b1;
        base = soc_pkg::clint_base;
      end else begin
        // Unmapped, or an instruction fetch outside the RAM
        err_req = 1'b1;
      end
    end
    bram_addr = bus_addr - base;
    clint_addr = bus_addr - base;
  end

  assign bram_wdata = bus_wdata;
  assign bram_wstrb = bus_wstrb;
  assign clint_wdata = bus_wdata;
  assign clint_wstrb = bus_wstrb;

  // Error responder behaves like any other target and answers one cycle later
  always_ff @(posedge clock) begin
    if (reset) begin
      err_ready <= 1'b0;
    end else begin
      err_ready <= err_req && !err_ready;
    end
  end

  always_comb begin
    bus_rdata = '0;
    bus_error = 1'b0;
    bus_ready = 1'b0;
    if (bram_ready) begin
      bus_rdata = bram_rdata;
      bus_ready = 1'b1;
    end else if (clint_ready) begin
      bus_rdata = clint_rdata;
      bus_ready = 1'b1;
    end else if (err_ready) begin
      bus_error = 1'b1;
      bus_ready = 1'b1;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    $onehot0({bram_valid, clint_valid, err_req}))
    else $error("address_decoder: more than one target selected");

endmodule

// File: design/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic clock,
  input  logic reset,
  input  logic fetch_valid,
  input  soc_pkg::addr_t fetch_addr,
  output soc_pkg::word_t fetch_rdata,
  output logic fetch_error,
  output logic fetch_ready,
  input  logic data_valid,
  input  soc_pkg::addr_t data_addr,
  input  soc_pkg::word_t data_wdata,
  input  soc_pkg::strb_t data_wstrb,
  output soc_pkg::word_t data_rdata,
  output logic data_error,
  output logic data_ready,
  output logic bus_valid,
  output logic bus_instr,
  output soc_pkg::addr_t bus_addr,
  output soc_pkg::word_t bus_wdata,
  output soc_pkg::strb_t bus_wstrb,
  input  soc_pkg::word_t bus_rdata,
  input  logic bus_error,
  input  logic bus_ready
);

  soc_pkg::grant_state_t state;
  soc_pkg::grant_state_t grant;
  logic last_data;

  // While idle the grant is decided combinationally so a lone request costs no cycle
  always_comb begin
    grant = state;
    if (state == soc_pkg::grant_idle) begin
      if (fetch_valid && (!data_valid || last_data)) begin
        grant = soc_pkg::grant_fetch;
      end else if (data_valid) begin
        grant = soc_pkg::grant_data;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= soc_pkg::grant_idle;
      last_data <= 1'b1;
    end else if (bus_ready) begin
      state <= soc_pkg::grant_idle;
      last_data <= (grant == soc_pkg::grant_data);
    end else begin
      state <= grant;
    end
  end

  always_comb begin
    bus_valid = 1'b0;
    bus_instr = 1'b0;
    bus_addr = '0;
    bus_wdata = '0;
    bus_wstrb = '0;
    case (grant)
      soc_pkg::grant_fetch: begin
        bus_valid = fetch_valid;
        bus_instr = 1'b1;
        bus_addr = fetch_addr;
      end
      soc_pkg::grant_data: begin
        bus_valid = data_valid;
        bus_addr = data_addr;
        bus_wdata = data_wdata;
        bus_wstrb = data_wstrb;
      end
      default: begin
      end
    endcase
  end

  assign fetch_ready = bus_ready && (grant == soc_pkg::grant_fetch);
  assign fetch_error = bus_error && (grant == soc_pkg::grant_fetch);
  assign fetch_rdata = (grant == soc_pkg::grant_fetch) ? bus_rdata : '0;
  assign data_ready = bus_ready && (grant == soc_pkg::grant_data);
  assign data_error = bus_error && (grant == soc_pkg::grant_data);
  assign data_rdata = (grant == soc_pkg::grant_data) ? bus_rdata : '0;

  // A target answer must only ever reach one requester
  assert property (@(posedge clock) disable iff (reset) !(fetch_ready && data_ready))
    else $error("bus_arbiter: fetch_ready and data_ready high together");

endmodule

// File: common/soc_pkg.sv
package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;
  typedef logic [63:0] time_t;

  // Block RAM region, 4 KiB of 32-bit words
  localparam addr_t bram_base = 32'h0000_0000;
  localparam addr_t bram_top = 32'h0000_1000;
  localparam int bram_words = 1024;

  typedef logic [$clog2(bram_words)-1:0] bram_index_t;

  // CLINT region with the usual RISC-V register layout
  localparam addr_t clint_base = 32'h0200_0000;
  localparam addr_t clint_top = 32'h0200_C000;

  localparam addr_t clint_msip_off = 32'h0000;
  localparam addr_t clint_mtimecmp_lo_off = 32'h4000;
  localparam addr_t clint_mtimecmp_hi_off = 32'h4004;
  localparam addr_t clint_mtime_lo_off = 32'hBFF8;
  localparam addr_t clint_mtime_hi_off = 32'hBFFC;

  typedef enum logic [1:0] {
    grant_idle,
    grant_fetch,
    grant_data
  } grant_state_t;

endpackage
